//--- flist.f
hw/hyper_pkg.sv
hw/hyper_reg_file.sv
hw/hyper_cfg_regs.sv
hw/hyper_cs_decoder.sv
hw/hyper_cs_sequencer.sv
hw/hyper_cfg_top.sv
tb/hyper_cfg_tb.sv

//--- hw/hyper_cfg_regs.sv
// Configuration register block: reset values, default address map,
// register file and packing into the configuration struct
module hyper_cfg_regs (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  hyper_pkg::reg_req_t   reg_req_i,
    output hyper_pkg::reg_rsp_t   reg_rsp_o,
    output hyper_pkg::hyper_cfg_t cfg_o,
    output logic                  cfg_upd_o
);
    import hyper_pkg::*;

    logic [NUM_REG-1:0][REG_DW-1:0] init_val;
    logic [NUM_REG-1:0][REG_DW-1:0] reg_val;
    logic [NUM_REG-1:0]             wr_evt;

    // Timing words, reset values from the package
    assign init_val[OFS_T_ACCESS / REG_BYTES]      = RST_T_ACCESS;
    assign init_val[OFS_T_ADDITIONAL / REG_BYTES]  = RST_T_ADDITIONAL;
    assign init_val[OFS_T_CS_MAX / REG_BYTES]      = RST_T_CS_MAX;
    assign init_val[OFS_T_RW_RECOVERY / REG_BYTES] = RST_T_RW_RECOVERY;

    assign cfg_o.t_access      = reg_val[OFS_T_ACCESS / REG_BYTES];
    assign cfg_o.t_additional  = reg_val[OFS_T_ADDITIONAL / REG_BYTES];
    assign cfg_o.t_cs_max      = reg_val[OFS_T_CS_MAX / REG_BYTES];
    assign cfg_o.t_rw_recovery = reg_val[OFS_T_RW_RECOVERY / REG_BYTES];

    // Back-to-back default windows, one stride per chip select
    for (genvar i = 0; i < NR_CS; i++) begin : g_range
        assign init_val[OFS_ADDR_MAP / REG_BYTES + 2*i]     = RANGE_STRIDE * i;
        assign init_val[OFS_ADDR_MAP / REG_BYTES + 2*i + 1] = RANGE_STRIDE * (i + 1) - 1;

        assign cfg_o.addr_map[i].start_addr = reg_val[OFS_ADDR_MAP / REG_BYTES + 2*i];
        assign cfg_o.addr_map[i].end_addr   = reg_val[OFS_ADDR_MAP / REG_BYTES + 2*i + 1];
    end

    hyper_reg_file u_reg_file (
        .clk_i      ( clk_i     ),
        .arst_n_i   ( arst_n_i  ),
        .init_val_i ( init_val  ),
        .reg_req_i  ( reg_req_i ),
        .reg_rsp_o  ( reg_rsp_o ),
        .reg_val_o  ( reg_val   ),
        .wr_evt_o   ( wr_evt    )
    );

    // Any range register written this cycle
    // holds off decoding until the new bound is stored
    assign cfg_upd_o = |wr_evt[NUM_REG-1:OFS_ADDR_MAP / REG_BYTES];

endmodule

//--- hw/hyper_cfg_top.sv
// Top level: configuration registers, chip-select decoder and sequencer
module hyper_cfg_top (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  hyper_pkg::reg_req_t         reg_req_i,
    output hyper_pkg::reg_rsp_t         reg_rsp_o,
    input  hyper_pkg::hyper_trans_t     trans_i,
    input  logic                        rwds_i,        // Extra latency request
    output logic                        trans_ready_o,
    output logic [hyper_pkg::NR_CS-1:0] cs_n_o,
    output logic                        cs_split_o,
    output logic                        trans_miss_o
);
    import hyper_pkg::*;

    hyper_cfg_t cfg;
    logic       cfg_upd;  // Range register written
    cs_sel_t    sel;      // Decoder stage output
    logic       sel_take;

    hyper_cfg_regs u_cfg_regs (
        .clk_i     ( clk_i     ),
        .arst_n_i  ( arst_n_i  ),
        .reg_req_i ( reg_req_i ),
        .reg_rsp_o ( reg_rsp_o ),
        .cfg_o     ( cfg       ),
        .cfg_upd_o ( cfg_upd   )
    );

    hyper_cs_decoder u_decoder (
        .clk_i         ( clk_i         ),
        .arst_n_i      ( arst_n_i      ),
        .cfg_i         ( cfg           ),
        .cfg_upd_i     ( cfg_upd       ),
        .trans_i       ( trans_i       ),
        .rwds_i        ( rwds_i        ),
        .trans_ready_o ( trans_ready_o ),
        .sel_o         ( sel           ),
        .sel_take_i    ( sel_take      )
    );

    hyper_cs_sequencer u_sequencer (
        .clk_i        ( clk_i        ),
        .arst_n_i     ( arst_n_i     ),
        .cfg_i        ( cfg          ),
        .sel_i        ( sel          ),
        .sel_take_o   ( sel_take     ),
        .cs_n_o       ( cs_n_o       ),
        .cs_split_o   ( cs_split_o   ),
        .trans_miss_o ( trans_miss_o )
    );

endmodule

//--- hw/hyper_cs_decoder.sv
// Address-to-chip-select decoder with a one-entry stage register
// and priority selection of the lowest matching range
module hyper_cs_decoder (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  hyper_pkg::hyper_cfg_t   cfg_i,
    input  logic                    cfg_upd_i,
    input  hyper_pkg::hyper_trans_t trans_i,
    input  logic                    rwds_i,
    output logic                    trans_ready_o,
    output hyper_pkg::cs_sel_t      sel_o,
    input  logic                    sel_take_i
);
    import hyper_pkg::*;

    logic [NR_CS-1:0] hit;     // Per-range match
    logic [NR_CS-1:0] hit_sel; // One-hot winner
    logic             accept;
    cs_sel_t          sel_q;   // Stage register

    // All ranges compared in parallel, bounds inclusive
    always_comb begin
        for (int i = 0; i < NR_CS; i++) begin
            hit[i] = (trans_i.addr >= cfg_i.addr_map[i].start_addr) &&
                     (trans_i.addr <= cfg_i.addr_map[i].end_addr);
        end
    end

    // Priority encoder, walks down so the lowest index is left standing
    always_comb begin
        hit_sel = '0;
        for (int i = NR_CS - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_sel    = '0;
                hit_sel[i] = 1'b1;
            end
        end
    end

    // Free stage or draining this cycle; blocked while a range is rewritten
    assign trans_ready_o = (!sel_q.valid || sel_take_i) && !cfg_upd_i;
    assign accept        = trans_i.valid && trans_ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sel_q <= '0;
        end else if (accept) begin
            sel_q.valid <= 1'b1;
            sel_q.sel   <= hit_sel;
            sel_q.miss  <= ~|hit;       // No range matched
            sel_q.len   <= trans_i.len;
            sel_q.rwds  <= rwds_i;      // Sampled with the transaction
        end else if (sel_take_i) begin
            sel_q.valid <= 1'b0;        // Taken, nothing new
        end
    end

    assign sel_o = sel_q;

endmodule

//--- hw/hyper_cs_sequencer.sv
// Chip-select sequencer: idle/active/recovery FSM with a down counter,
// latency cap with split flag and immediate miss reporting
module hyper_cs_sequencer (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  hyper_pkg::hyper_cfg_t           cfg_i,
    input  hyper_pkg::cs_sel_t              sel_i,
    output logic                            sel_take_o,
    output logic [hyper_pkg::NR_CS-1:0]     cs_n_o,
    output logic                            cs_split_o,
    output logic                            trans_miss_o
);
    import hyper_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACTIVE, // Chip select low
        S_RECOV   // Read-write recovery
    } state_e;

    state_e            state_q;
    logic [REG_DW-1:0] cnt_q;    // Remaining cycles in current phase
    logic              last;     // Final cycle of the phase
    logic [NR_CS-1:0]  cs_q;     // Selected chip select
    logic              split_q;  // Current access was capped

    logic [REG_DW+1:0] dur_full; // Uncapped, headroom for the sum
    logic [REG_DW-1:0] dur;
    logic              over;

    // Latency plus transfer length, capped by t_cs_max
    always_comb begin
        dur_full = cfg_i.t_access + (sel_i.rwds ? cfg_i.t_additional : '0) + sel_i.len;
        over     = dur_full > cfg_i.t_cs_max;
        dur      = over ? cfg_i.t_cs_max : dur_full[REG_DW-1:0];
    end

    assign last = cnt_q <= 1; // Zero length still gives one cycle

    // Take only when idle; misses leave at once
    assign sel_take_o   = (state_q == S_IDLE) && sel_i.valid;
    assign trans_miss_o = sel_take_o && sel_i.miss;

    assign cs_n_o     = (state_q == S_ACTIVE) ? ~cs_q : '1;
    assign cs_split_o = (state_q == S_ACTIVE) && split_q && last;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (sel_take_o && !sel_i.miss) begin
                        state_q <= S_ACTIVE;
                        cnt_q   <= dur;
                    end
                end
                S_ACTIVE: begin
                    if (last) begin
                        // Release, then recovery if any is configured
                        if (cfg_i.t_rw_recovery != '0) begin
                            state_q <= S_RECOV;
                            cnt_q   <= cfg_i.t_rw_recovery;
                        end else begin
                            state_q <= S_IDLE;
                        end
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                S_RECOV: begin
                    if (last) begin
                        state_q <= S_IDLE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Payload of the taken item
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cs_q    <= '0;
            split_q <= 1'b0;
        end else if (sel_take_o) begin
            cs_q    <= sel_i.sel;
            split_q <= over;
        end
    end

endmodule

//--- hw/hyper_pkg.sv
// Widths, register map offsets, reset values and the bus and transaction
// structs shared by the HyperBus chip-select subsystem
package hyper_pkg;

    localparam int unsigned NR_CS        = 2;                  // Chip selects
    localparam int unsigned REG_DW       = 32;                 // Register data width
    localparam int unsigned REG_AW       = 32;                 // Register address width
    localparam int unsigned REG_BYTES    = REG_DW / 8;         // Strobe bits per word
    localparam int unsigned NUM_REG      = 4 + 2 * NR_CS;      // Timing words plus ranges
    localparam int unsigned REG_IDX_W    = $clog2(NUM_REG);    // Word index width
    localparam int unsigned REG_MAP_SIZE = NUM_REG * REG_BYTES; // First unmapped offset

    // Byte offsets of the register map
    localparam logic [REG_AW-1:0] OFS_T_ACCESS      = 32'h00;
    localparam logic [REG_AW-1:0] OFS_T_ADDITIONAL  = 32'h04;
    localparam logic [REG_AW-1:0] OFS_T_CS_MAX      = 32'h08;
    localparam logic [REG_AW-1:0] OFS_T_RW_RECOVERY = 32'h0C;
    localparam logic [REG_AW-1:0] OFS_ADDR_MAP      = 32'h10; // Start/end pairs, 8 bytes each

    localparam logic [REG_DW-1:0] RANGE_STRIDE = 32'h40_0000; // Default window per CS

    // Timing reset values in clock cycles
    localparam logic [REG_DW-1:0] RST_T_ACCESS      = 32'd6;
    localparam logic [REG_DW-1:0] RST_T_ADDITIONAL  = 32'd6;
    localparam logic [REG_DW-1:0] RST_T_CS_MAX      = 32'd666;
    localparam logic [REG_DW-1:0] RST_T_RW_RECOVERY = 32'd6;

    // Register bus request, held by the master until ready
    typedef struct packed {
        logic [REG_AW-1:0]    addr;
        logic                 write;
        logic [REG_DW-1:0]    wdata;
        logic [REG_BYTES-1:0] wstrb;
        logic                 valid;
    } reg_req_t;

    typedef struct packed {
        logic [REG_DW-1:0] rdata;
        logic              ready; // Same cycle as valid
        logic              error; // Unaligned or unmapped
    } reg_rsp_t;

    typedef struct packed {
        logic [REG_DW-1:0] start_addr; // Inclusive
        logic [REG_DW-1:0] end_addr;   // Inclusive
    } addr_range_t;

    typedef struct packed {
        logic [REG_DW-1:0]            t_access;
        logic [REG_DW-1:0]            t_additional;
        logic [REG_DW-1:0]            t_cs_max;
        logic [REG_DW-1:0]            t_rw_recovery;
        addr_range_t [NR_CS-1:0]      addr_map;
    } hyper_cfg_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [15:0] len;   // Transfer length in clock cycles
        logic        write;
    } hyper_trans_t;

    // Decoded request between decoder and sequencer
    typedef struct packed {
        logic             valid;
        logic [NR_CS-1:0] sel;  // One-hot, zero on miss
        logic             miss;
        logic [15:0]      len;
        logic             rwds; // Extra latency requested
    } cs_sel_t;

endpackage

//--- hw/hyper_reg_file.sv
// Uniform array of 32-bit registers with reset values,
// byte-strobed writes and same-cycle reads over the register bus
module hyper_reg_file (
    input  logic                                                 clk_i,
    input  logic                                                 arst_n_i,
    input  logic [hyper_pkg::NUM_REG-1:0][hyper_pkg::REG_DW-1:0] init_val_i,
    input  hyper_pkg::reg_req_t                                  reg_req_i,
    output hyper_pkg::reg_rsp_t                                  reg_rsp_o,
    output logic [hyper_pkg::NUM_REG-1:0][hyper_pkg::REG_DW-1:0] reg_val_o,
    output logic [hyper_pkg::NUM_REG-1:0]                        wr_evt_o
);
    import hyper_pkg::*;

    logic [NUM_REG-1:0][REG_DW-1:0] regs_q;
    logic [REG_IDX_W-1:0]           idx;    // Word index from byte address
    logic                           mapped;

    assign idx = reg_req_i.addr[REG_IDX_W+1:2];

    // Word aligned and inside the map
    assign mapped = (reg_req_i.addr[1:0] == 2'b00) &&
                    (reg_req_i.addr < REG_MAP_SIZE);

    // One write event per addressed register
    always_comb begin
        wr_evt_o = '0;
        if (reg_req_i.valid && reg_req_i.write && mapped) begin
            wr_evt_o[idx] = 1'b1;
        end
    end

    // Storage, loaded from init_val_i on reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs_q <= init_val_i;
        end else begin
            for (int i = 0; i < NUM_REG; i++) begin
                for (int b = 0; b < REG_BYTES; b++) begin
                    // Only strobed bytes of the hit word
                    if (wr_evt_o[i] && reg_req_i.wstrb[b]) begin
                        regs_q[i][8*b +: 8] <= reg_req_i.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // Response completes in the request cycle
    always_comb begin
        reg_rsp_o.ready = reg_req_i.valid;
        reg_rsp_o.error = reg_req_i.valid && !mapped; // Bad address
        reg_rsp_o.rdata = '0;
        if (reg_req_i.valid && mapped && !reg_req_i.write) begin
            reg_rsp_o.rdata = regs_q[idx]; // Current value, before any write
        end
    end

    assign reg_val_o = regs_q; // Flat view for the config packer

endmodule

//--- tb/hyper_cfg_tb.sv
// Directed testbench for the HyperBus chip-select subsystem
// Bus and transaction tasks, compare tasks, watchdog, result report
module hyper_cfg_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import hyper_pkg::*;

    localparam int CLK_HALF = 20;
    localparam int WAIT_MAX = 100;                          // Give-up point of any wait loop
    localparam int RUN_CYC  = 4 + (20 + 20 + 80 + 40 + 60 + 60) + 200; // Reset, tests, margin

    logic             clk = 1'b0;
    logic             arst_n;
    reg_req_t         req;
    reg_rsp_t         rsp;
    hyper_trans_t     trans;
    logic             rwds;
    logic             trans_ready;
    logic [NR_CS-1:0] cs_n;
    logic             cs_split;
    logic             trans_miss;
    int               errors = 0;
    int               tests_run = 0;
    int               tests_failed = 0;
    logic [31:0]      rng = 32'he180;                       // xorshift state

    hyper_cfg_top DUT (
        .clk_i         ( clk         ),
        .arst_n_i      ( arst_n      ),
        .reg_req_i     ( req         ),
        .reg_rsp_o     ( rsp         ),
        .trans_i       ( trans       ),
        .rwds_i        ( rwds        ),
        .trans_ready_o ( trans_ready ),
        .cs_n_o        ( cs_n        ),
        .cs_split_o    ( cs_split    ),
        .trans_miss_o  ( trans_miss  )
    );

    always #(CLK_HALF) clk = ~clk;

    initial begin
        #(RUN_CYC * 2 * CLK_HALF);
        $display("watchdog expired, the tests did not complete in time");
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic reg_rsp_t make_rsp(input logic [31:0] rdata, input logic error);
        reg_rsp_t r;
        r.rdata = rdata;
        r.ready = 1'b1;                                     // Always same cycle
        r.error = error;
        return r;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_rsp(input string name, input reg_rsp_t got, input reg_rsp_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s got %h/%b/%b expected %h/%b/%b (rdata/ready/error)",
                     $time, name, got.rdata, got.ready, got.error,
                     exp.rdata, exp.ready, exp.error);
        end
    endtask

    task automatic compare_cs(input string name,
                              input logic [NR_CS-1:0] got_vec, input logic [NR_CS-1:0] exp_vec,
                              input int got_cyc, input int exp_cyc);
        if (got_vec !== exp_vec || got_cyc != exp_cyc) begin
            errors++;
            $display("ERROR @%0t: %s got cs_n %b for %0d cycles expected %b for %0d cycles",
                     $time, name, got_vec, got_cyc, exp_vec, exp_cyc);
        end
    endtask

    // One register bus access, entered and left 2 ns after a rising edge
    task automatic bus_cycle(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output reg_rsp_t r);
        int n = 0;
        req.addr  = addr;
        req.write = wr;
        req.wdata = data;
        req.wstrb = strb;
        req.valid = 1'b1;
        do begin
            @(negedge clk);                                 // Response stable mid-cycle
            n++;
        end while (!rsp.ready && n < WAIT_MAX);
        r = rsp;
        if (!rsp.ready) begin
            errors++;
            $display("register bus never raised ready for address %h", addr);
        end
        @(posedge clk);
        #2;
        req.valid = 1'b0;
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output reg_rsp_t r);
        bus_cycle(1'b1, addr, data, strb, r);
    endtask

    task automatic reg_read(input logic [31:0] addr, output reg_rsp_t r);
        bus_cycle(1'b0, addr, '0, '0, r);
    endtask

    // Holds the transaction until accepted; returns 2 ns after the accepting edge
    task automatic send_trans(input logic [31:0] addr, input logic [15:0] len, input logic lat);
        int n = 0;
        trans.addr  = addr;
        trans.len   = len;
        trans.write = rng[0];                               // Direction does not affect timing
        trans.valid = 1'b1;
        rwds        = lat;
        do begin
            @(negedge clk);
            n++;
        end while (!trans_ready && n < WAIT_MAX);
        if (!trans_ready) begin
            errors++;
            $display("transaction at %h was never accepted", addr);
        end
        @(posedge clk);
        #2;
        trans.valid = 1'b0;
        rwds        = 1'b0;
    endtask

    // High cycles before a chip select, then its low cycles and split pulses
    task automatic watch_cs(output logic [NR_CS-1:0] vec, output int wait_cyc,
                            output int low_cyc, output int splits, output logic split_last);
        wait_cyc   = 0;
        low_cyc    = 0;
        splits     = 0;
        split_last = 1'b0;
        @(negedge clk);
        while (&cs_n && wait_cyc < WAIT_MAX) begin
            wait_cyc++;
            @(negedge clk);
        end
        vec = cs_n;
        if (&vec) begin
            errors++;
            $display("no chip select went low within %0d cycles", WAIT_MAX);
        end
        while (cs_n == vec && !(&cs_n) && low_cyc < WAIT_MAX) begin
            low_cyc++;
            splits    += cs_split;
            split_last = cs_split;                          // Kept from the final low cycle
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    // Miss pulses and chip-select activity over a fixed window
    task automatic watch_miss(input int window, output int misses, output int first_at,
                              output int low_cyc);
        misses   = 0;
        first_at = 0;
        low_cyc  = 0;
        for (int c = 1; c <= window; c++) begin
            @(negedge clk);
            if (trans_miss && misses == 0) begin
                first_at = c;
            end
            misses  += trans_miss;
            low_cyc += !(&cs_n);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic read_reset_values();
        int          e0 = errors;
        reg_rsp_t    r;
        logic [31:0] exp;
        for (int i = 0; i < NUM_REG; i++) begin
            if (i < 4) begin
                exp = (i == 2) ? 32'd666 : 32'd6;          // Timing words
            end else begin
                exp = 32'h40_0000 * ((i - 4) / 2) + ((i % 2) ? 32'h3F_FFFF : 32'h0);
            end
            reg_read(4 * i, r);
            compare_word($sformatf("reset value at %h", 4 * i), r.rdata, exp);
        end
        reg_read(32'h20, r);
        compare_rsp("read of 0x20", r, make_rsp('0, 1'b1));
        end_test("reset_values", e0);
    endtask

    task automatic write_with_strobes();
        int          e0 = errors;
        reg_rsp_t    r;
        logic [31:0] data;
        rng  = xorshift(rng);
        data = rng;
        reg_write(32'h0C, data, 4'b0101, r);
        compare_rsp("strobed write", r, make_rsp('0, 1'b0));
        reg_read(32'h0C, r);
        compare_word("t_rw_recovery", r.rdata, (32'd6 & 32'hFF00_FF00) | (data & 32'h00FF_00FF));
        reg_write(32'h0C, 32'd6, 4'hF, r);                 // Restore
        rng = xorshift(rng);
        reg_write(32'h05, rng, 4'hF, r);
        compare_rsp("unaligned write", r, make_rsp('0, 1'b1));
        reg_read(32'h04, r);
        compare_word("t_additional", r.rdata, 32'd6);
        end_test("strobe_write", e0);
    endtask

    task automatic hit_default_ranges();
        int               e0 = errors;
        logic [NR_CS-1:0] vec;
        int               wait_cyc, low_cyc, splits;
        logic             split_last;
        rng = xorshift(rng);
        send_trans(rng & 32'h3F_FFFF, 16'd10, 1'b0);
        watch_cs(vec, wait_cyc, low_cyc, splits, split_last);
        compare_cs("range 0 start", vec, 2'b10, wait_cyc, 1);
        compare_cs("range 0 length", vec, 2'b10, low_cyc, 6 + 10);
        idle(10);
        rng = xorshift(rng);
        send_trans(32'h40_0000 | (rng & 32'h3F_FFFF), 16'd5, 1'b1);
        watch_cs(vec, wait_cyc, low_cyc, splits, split_last);
        compare_cs("range 1 start", vec, 2'b01, wait_cyc, 1);
        compare_cs("range 1 with rwds", vec, 2'b01, low_cyc, 6 + 6 + 5);
        compare_word("cs_split_o pulses", splits, 0);
        idle(10);
        end_test("default_ranges", e0);
    endtask

    task automatic cap_chip_select();
        int               e0 = errors;
        reg_rsp_t         r;
        logic [NR_CS-1:0] vec;
        int               wait_cyc, low_cyc, splits;
        logic             split_last;
        reg_write(32'h08, 32'd8, 4'hF, r);
        send_trans(32'h100, 16'd20, 1'b0);                 // 26 cycles uncapped
        watch_cs(vec, wait_cyc, low_cyc, splits, split_last);
        compare_cs("capped chip select", vec, 2'b10, low_cyc, 8);
        compare_word("cs_split_o pulses", splits, 1);
        compare_word("cs_split_o in last cycle", split_last, 1);
        idle(10);
        reg_write(32'h08, 32'd666, 4'hF, r);
        end_test("cs_cap", e0);
    endtask

    task automatic miss_all_ranges();
        int       e0 = errors;
        reg_rsp_t r;
        int       misses, first_at, low_cyc;
        send_trans(32'h90_0000, 16'd4, 1'b0);              // Beyond both windows
        watch_miss(12, misses, first_at, low_cyc);
        compare_word("trans_miss_o pulses", misses, 1);
        compare_word("trans_miss_o cycle", first_at, 1);
        compare_word("cs_n_o low cycles", low_cyc, 0);
        reg_write(32'h1C, 32'h4F_FFFF, 4'hF, r);           // Shrink range 1
        send_trans(32'h60_0000, 16'd4, 1'b0);
        watch_miss(12, misses, first_at, low_cyc);
        compare_word("trans_miss_o pulses after rewrite", misses, 1);
        compare_word("cs_n_o low cycles after rewrite", low_cyc, 0);
        reg_write(32'h1C, 32'h7F_FFFF, 4'hF, r);
        end_test("miss", e0);
    endtask

    task automatic run_back_to_back();
        int               e0 = errors;
        logic [NR_CS-1:0] vec_a, vec_b;
        int               wait_a, low_a, wait_b, low_b, splits;
        logic             split_last;
        send_trans(32'h1000, 16'd4, 1'b0);
        fork
            begin
                watch_cs(vec_a, wait_a, low_a, splits, split_last);
                watch_cs(vec_b, wait_b, low_b, splits, split_last);
            end
            begin
                send_trans(32'h41_0000, 16'd3, 1'b0);      // Enters the stage behind the first
                @(negedge clk);
                compare_word("trans_ready_o with stage full", trans_ready, 0);
                @(posedge clk);
                #2;
            end
        join
        compare_cs("first start", vec_a, 2'b10, wait_a, 1);
        compare_cs("first chip select", vec_a, 2'b10, low_a, 6 + 4);
        // Release cycle seen by first watch
        compare_cs("recovery gap", vec_b, 2'b01, wait_b + 1, 6 + 1);
        compare_cs("second chip select", vec_b, 2'b01, low_b, 6 + 3);
        idle(10);
        end_test("back_to_back", e0);
    endtask

    initial begin
        arst_n = 1'b0;
        req    = '0;
        trans  = '0;
        rwds   = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        read_reset_values();
        write_with_strobes();
        hit_default_ranges();
        cap_chip_select();
        miss_all_ranges();
        run_back_to_back();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
